// File: source/rv_mem_pkg.sv
// Shared widths, type encodings and pipeline bundles, imported by every RTL module of the MEM/WB path
`default_nettype none

package rv_mem_pkg;

    // ====================
    // Widths
    // ====================
    localparam int DATA_W      = 32;   // Register and memory word
    localparam int DMEM_ADDR_W = 11;   // Byte address into 2 KiB
    localparam int DMEM_WORDS  = 512;  // 2 KiB / 4 bytes
    localparam int REG_ADDR_W  = 5;    // x0..x31

    typedef logic [DATA_W-1:0]      word_t;
    typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t;
    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;

    // ====================
    // Encodings
    // ====================
    // Store size, low bits of the RISC-V store funct3
    typedef enum logic [1:0] {
        ST_BYTE = 2'b00,
        ST_HALF = 2'b01,
        ST_WORD = 2'b10
    } store_type_t;

    // Load size and extension, same as load funct3
    typedef enum logic [2:0] {
        LD_B  = 3'b000,
        LD_H  = 3'b001,
        LD_W  = 3'b010,
        LD_BU = 3'b100,
        LD_HU = 3'b101
    } load_type_t;

    // Register-file result source
    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,
        RES_PC4 = 2'b10
    } result_src_t;

    // ====================
    // Pipeline bundles
    // ====================
    typedef struct packed {
        logic        regwrite;    // Instruction writes rd
        logic        memwrite;    // Store
        result_src_t resultsrc;
        store_type_t storetype;
        load_type_t  loadtype;
        word_t       alu_result;  // Also the memory address
        word_t       write_data;  // Store data from rs2
        reg_addr_t   rd_addr;
        dmem_addr_t  pc4;
    } ex_mem_t;                   // 89 bits

    typedef struct packed {
        logic        regwrite;
        result_src_t resultsrc;
        load_type_t  loadtype;
        word_t       read_data;   // Raw aligned word from memory
        word_t       alu_result;
        reg_addr_t   rd_addr;
        dmem_addr_t  pc4;
    } mem_wb_t;                   // 86 bits

    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;
    } rf_write_t;                 // 38 bits

endpackage

`default_nettype wire

// File: source/data_memory.sv
// 2 KiB byte-lane data memory, combinational word read and clocked word/half/byte store
`timescale 1ns/10ps
`default_nettype none

module data_memory
    import rv_mem_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_we,          // Store strobe, one cycle
    input  wire dmem_addr_t  i_addr,        // Byte address
    input  wire word_t       i_wdata,       // Store data, low bits used for sub-word
    input  wire store_type_t i_storetype,   // Store size
    output word_t            o_rdata        // Full aligned word
);

    word_t                  mem [DMEM_WORDS];  // Storage, no reset
    logic [DMEM_ADDR_W-3:0] word_idx;          // Address bits 10..2
    logic [1:0]             byte_off;          // Lane offset within the word
    logic [3:0]             lane_en;           // Byte enables for the store
    word_t                  lane_data;         // Store data replicated onto lanes

    assign word_idx = i_addr[DMEM_ADDR_W-1:2];
    assign byte_off = i_addr[1:0];

    // ====================
    // Lane selection
    // ====================
    // Sub-word data is replicated so every lane already holds it,
    // the enables then pick which lanes get written
    always_comb begin
        lane_en   = 4'b0000;
        lane_data = i_wdata;
        case (i_storetype)
            ST_BYTE: begin
                lane_en   = 4'b0001 << byte_off;       // Any offset
                lane_data = {4{i_wdata[7:0]}};
            end
            ST_HALF: begin
                // Bit 0 ignored, halfword lands on lanes 0-1 or 2-3
                lane_en   = byte_off[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{i_wdata[15:0]}};
            end
            ST_WORD: begin
                lane_en   = 4'b1111;                   // Offset ignored
                lane_data = i_wdata;
            end
            default: begin
                lane_en   = 4'b0000;                   // Unused code writes nothing
                lane_data = i_wdata;
            end
        endcase
    end

    // ====================
    // Store
    // ====================
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (lane_en[lane]) begin
                    mem[word_idx][8*lane +: 8] <= lane_data[8*lane +: 8];
                end
            end
        end
    end

    // Read is combinational, same-cycle store not yet visible
    assign o_rdata = mem[word_idx];

endmodule

`default_nettype wire

// File: source/memory_stage.sv
// Memory-access stage, drives the data memory from the EX bundle and holds the MEM/WB register
`timescale 1ns/10ps
`default_nettype none

module memory_stage
    import rv_mem_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_rst_n,

    // From EX
    input  wire ex_mem_t     i_ex,

    // Data memory interface
    output logic             o_dmem_we,
    output dmem_addr_t       o_dmem_addr,
    output word_t            o_dmem_wdata,
    output store_type_t      o_storetype,
    input  wire word_t       i_dmem_rdata,

    // To WB
    output mem_wb_t          o_mem_wb
);

    mem_wb_t mem_wb_d;   // Next value of the MEM/WB register

    // ====================
    // Memory interface
    // ====================
    // Plain strobes, each access completes in the cycle it is presented
    assign o_dmem_we    = i_ex.memwrite;
    assign o_dmem_addr  = i_ex.alu_result[DMEM_ADDR_W-1:0];  // Low bits of the ALU sum
    assign o_dmem_wdata = i_ex.write_data;                   // rs2 value
    assign o_storetype  = i_ex.storetype;                    // Size of the store

    // ====================
    // MEM/WB register
    // ====================
    // Only the fields WB needs are carried forward
    always_comb begin
        mem_wb_d.regwrite   = i_ex.regwrite;
        mem_wb_d.resultsrc  = i_ex.resultsrc;
        mem_wb_d.loadtype   = i_ex.loadtype;    // Extension done in WB
        mem_wb_d.read_data  = i_dmem_rdata;     // Whole word, lane pick later
        mem_wb_d.alu_result = i_ex.alu_result;  // Needs bits 1..0 for the load offset
        mem_wb_d.rd_addr    = i_ex.rd_addr;
        mem_wb_d.pc4        = i_ex.pc4;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem_wb <= '0;                     // regwrite low, no RF write after reset
        end else begin
            o_mem_wb <= mem_wb_d;               // New bundle every cycle, no stall
        end
    end

endmodule

`default_nettype wire

// File: source/writeback_stage.sv
// Writeback stage, extracts and extends load data and selects the register-file write
`timescale 1ns/10ps
`default_nettype none

module writeback_stage
    import rv_mem_pkg::*;
(
    input  wire mem_wb_t i_mem_wb,     // Registered MEM/WB bundle
    output rf_write_t    o_rf_write    // Register-file write port
);

    logic [1:0] addr_off;     // Byte offset from the address
    logic [1:0] ld_off;       // Offset after alignment to the load size
    word_t      shifted;      // Read word moved down to lane 0
    word_t      load_data;    // Extended load value
    word_t      result;       // Selected RF data

    assign addr_off = i_mem_wb.alu_result[1:0];

    // ====================
    // Load extraction
    // ====================
    always_comb begin
        // Unused low bits dropped, as on the store side
        case (i_mem_wb.loadtype)
            LD_B, LD_BU: ld_off = addr_off;
            LD_H, LD_HU: ld_off = {addr_off[1], 1'b0};
            default:     ld_off = 2'b00;
        endcase

        shifted = i_mem_wb.read_data >> {ld_off, 3'b000};

        case (i_mem_wb.loadtype)
            LD_B:    load_data = {{(DATA_W-8){shifted[7]}}, shifted[7:0]};
            LD_BU:   load_data = {{(DATA_W-8){1'b0}}, shifted[7:0]};
            LD_H:    load_data = {{(DATA_W-16){shifted[15]}}, shifted[15:0]};
            LD_HU:   load_data = {{(DATA_W-16){1'b0}}, shifted[15:0]};
            default: load_data = i_mem_wb.read_data;    // LD_W
        endcase
    end

    // ====================
    // Result select
    // ====================
    always_comb begin
        case (i_mem_wb.resultsrc)
            RES_MEM: result = load_data;
            RES_PC4: result = {{(DATA_W-DMEM_ADDR_W){1'b0}}, i_mem_wb.pc4};  // Zero-extended
            default: result = i_mem_wb.alu_result;                            // RES_ALU
        endcase
    end

    // x0 is hardwired, never write it
    always_comb begin
        o_rf_write.we   = i_mem_wb.regwrite && (i_mem_wb.rd_addr != '0);
        o_rf_write.addr = i_mem_wb.rd_addr;
        o_rf_write.data = result;
    end

endmodule

`default_nettype wire

// File: source/rv_mem_top.sv
// Top of the MEM/WB subsystem, EX bundle in and register-file write out one cycle later
`timescale 1ns/10ps
`default_nettype none

module rv_mem_top
    import rv_mem_pkg::*;
(
    input  wire logic    i_clk,
    input  wire logic    i_rst_n,
    input  wire ex_mem_t i_ex,          // Stands in for the EX stage
    output rf_write_t    o_rf_write     // To the register file
);

    // ====================
    // Interconnect
    // ====================
    logic        dmem_we;
    dmem_addr_t  dmem_addr;
    word_t       dmem_wdata;
    store_type_t dmem_storetype;
    word_t       dmem_rdata;             // Combinational read back into MEM
    mem_wb_t     mem_wb;                 // MEM/WB register contents

    // MEM stage and data memory act in the same cycle
    memory_stage u_memory_stage (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_ex         (i_ex),
        .o_dmem_we    (dmem_we),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata),
        .o_storetype  (dmem_storetype),
        .i_dmem_rdata (dmem_rdata),
        .o_mem_wb     (mem_wb)
    );

    data_memory u_data_memory (
        .i_clk       (i_clk),
        .i_we        (dmem_we),
        .i_addr      (dmem_addr),
        .i_wdata     (dmem_wdata),
        .i_storetype (dmem_storetype),
        .o_rdata     (dmem_rdata)
    );

    // WB works on the registered bundle
    writeback_stage u_writeback_stage (
        .i_mem_wb   (mem_wb),
        .o_rf_write (o_rf_write)
    );

endmodule

`default_nettype wire

// File: test/rv_mem_properties.sv
// Concurrent checks on reset and register-file write legality that bind into rv_mem_top in the testbench build
`timescale 1ns/10ps
`default_nettype none

module rv_mem_properties
    import rv_mem_pkg::*;
(
    input wire logic      i_clk,
    input wire logic      i_rst_n,
    input wire ex_mem_t   i_ex,          // EX bundle seen by the top
    input wire rf_write_t o_rf_write     // RF write port of the top
);

    int fail_count;                      // Failed assertions, read by the testbench

    // ====================
    // Reset
    // ====================
    // Asynchronous clear of MEM/WB keeps the write port quiet
    a_no_write_in_reset : assert property (
        @(posedge i_clk) !i_rst_n |-> !o_rf_write.we
    ) else begin
        fail_count++;
        $error("RF write enable high while reset is asserted");
    end

    // ====================
    // Write port
    // ====================
    a_no_x0_write : assert property (
        @(posedge i_clk) o_rf_write.we |-> (o_rf_write.addr != '0)
    ) else begin
        fail_count++;
        $error("RF write enable high for register x0");
    end

    // One-cycle latency from the EX bundle to the write enable
    a_we_follows_regwrite : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (i_ex.rd_addr != '0) |=> (o_rf_write.we == $past(i_ex.regwrite))
    ) else begin
        fail_count++;
        $error("RF write enable does not follow regwrite one cycle later");
    end

endmodule

bind rv_mem_top rv_mem_properties u_properties (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_ex       (i_ex),
    .o_rf_write (o_rf_write)
);

`default_nettype wire

// File: test/tb_rv_mem.sv
// Drives rv_mem_top from the vector file and random word traffic and checks writes against a memory model
`timescale 1ns/10ps
`default_nettype none

module tb_rv_mem
    import rv_mem_pkg::*;
();

    localparam int RESET_TIMEOUT = 20;     // Cycles allowed for reset release
    localparam int MAX_LINES     = 1000;   // Upper bound on vector file length
    localparam int RAND_COUNT    = 16;     // Random stores and as many reloads

    // Expected RF write for the cycle after its vector
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        word_t     data;          // From the vector file or the model
        logic      use_model;     // Word load compared with the model as well
        word_t     model_data;
    } expect_t;

    logic      i_clk;
    logic      i_rst_n;
    ex_mem_t   i_ex;
    rf_write_t o_rf_write;

    word_t       ref_mem [DMEM_WORDS];   // Mirror of the data memory
    expect_t     pending [$];            // Writes still to be seen
    integer      seed;
    int          fd;
    int          code;
    int          n;
    int          line_no;
    int          wait_cycles;
    string       line;
    logic [31:0] f_rw, f_mw, f_res, f_st, f_ld;
    logic [31:0] f_alu, f_wd, f_rd, f_pc, f_exp;
    ex_mem_t     vec;
    logic [8:0]  rand_idx [RAND_COUNT];   // Word indices used by random stores
    logic [31:0] r_val;

    rv_mem_top u_dut (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_ex       (i_ex),
        .o_rf_write (o_rf_write)
    );

    // ====================
    // Clock and reset
    // ====================
    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;       // 20 ns period
    end

    initial begin
        i_rst_n = 1'b0;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        i_rst_n = 1'b1;                   // Released on a falling edge
    end

    // ====================
    // Helpers
    // ====================
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is 0x%08h, expected 0x%08h at %0t",
                     name, actual, expected, $time);
            $display("Test FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "%s", why);
    endtask

    // Bound assertions count their failures
    task automatic check_assertions();
        if (u_dut.u_properties.fail_count != 0) begin
            abort_run("A bound assertion on rv_mem_top failed");
        end
    endtask

    // Comment and blank lines carry no vector
    function automatic bit skip_line(input string s);
        byte c;
        if (s.len() == 0) begin
            return 1'b1;
        end
        c = s.getc(0);
        return (c == "#") || (c == "\n") || (c == "\r") || (c == " ");
    endfunction

    // Word ignores the offset, half uses address bit 1 and byte uses bits 1..0
    task automatic model_store(input dmem_addr_t addr, input word_t data,
                               input store_type_t st);
        logic [8:0] idx;
        idx = addr[DMEM_ADDR_W-1:2];
        case (st)
            ST_WORD: ref_mem[idx] = data;
            ST_HALF: begin
                if (addr[1]) ref_mem[idx][31:16] = data[15:0];
                else         ref_mem[idx][15:0]  = data[15:0];
            end
            ST_BYTE: ref_mem[idx][8*addr[1:0] +: 8] = data[7:0];
            default: ;                          // Nothing stored
        endcase
    endtask

    // Checks last cycle's write and drives the next vector on a falling edge
    task automatic apply_vector(input ex_mem_t v, input word_t exp_data);
        expect_t e;
        expect_t prev;
        check_assertions();
        if (pending.size() > 0) begin
            prev = pending.pop_front();
            check_value("o_rf_write.we", o_rf_write.we, prev.we);
            if (prev.we) begin
                check_value("o_rf_write.addr", o_rf_write.addr, prev.addr);
                check_value("o_rf_write.data", o_rf_write.data, prev.data);
                if (prev.use_model) begin
                    check_value("o_rf_write.data vs model", o_rf_write.data,
                                prev.model_data);
                end
            end
        end
        e.we         = v.regwrite && (v.rd_addr != '0);
        e.addr       = v.rd_addr;
        e.data       = exp_data;
        e.use_model  = (v.resultsrc == RES_MEM) && (v.loadtype == LD_W);
        e.model_data = ref_mem[v.alu_result[DMEM_ADDR_W-1:2]];   // Before this store
        pending.push_back(e);
        if (v.memwrite) begin
            model_store(v.alu_result[DMEM_ADDR_W-1:0], v.write_data, v.storetype);
        end
        i_ex = v;
        @(negedge i_clk);
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        i_ex        = '0;
        seed        = 46;

        wait_cycles = 0;
        while (i_rst_n !== 1'b1) begin
            @(posedge i_clk);
            wait_cycles++;
            if (wait_cycles > RESET_TIMEOUT) begin
                abort_run("Timeout: reset was not released");
            end
        end
        @(negedge i_clk);
        check_value("o_rf_write.we", o_rf_write.we, 1'b0);   // Cleared by reset

        // Directed vectors from the file
        fd = $fopen("test/rv_mem_tests.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the vector file test/rv_mem_tests.txt");
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line_no++;
            if (line_no > MAX_LINES) begin
                abort_run("Timeout: vector file did not end within the line limit");
            end
            code = $fgets(line, fd);
            if (code > 0 && !skip_line(line)) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f_rw, f_mw, f_res,
                            f_st, f_ld, f_alu, f_wd, f_rd, f_pc, f_exp);
                if (n != 10) begin
                    abort_run($sformatf("Malformed vector on line %0d", line_no));
                end
                vec            = '0;
                vec.regwrite   = f_rw[0];
                vec.memwrite   = f_mw[0];
                vec.resultsrc  = result_src_t'(f_res[1:0]);
                vec.storetype  = store_type_t'(f_st[1:0]);
                vec.loadtype   = load_type_t'(f_ld[2:0]);
                vec.alu_result = f_alu;
                vec.write_data = f_wd;
                vec.rd_addr    = f_rd[REG_ADDR_W-1:0];
                vec.pc4        = f_pc[DMEM_ADDR_W-1:0];
                apply_vector(vec, f_exp);
            end
        end
        $fclose(fd);

        // Random word stores to the upper half followed by reloads of the same words
        for (int i = 0; i < RAND_COUNT; i++) begin
            r_val          = $random(seed);
            rand_idx[i]    = {1'b1, r_val[7:0]};
            r_val          = $random(seed);
            vec            = '0;
            vec.memwrite   = 1'b1;
            vec.storetype  = ST_WORD;
            vec.loadtype   = LD_W;
            vec.alu_result = {r_val[31:11], rand_idx[i], 2'b00};   // High bits unused
            vec.write_data = $random(seed);
            apply_vector(vec, '0);
        end
        for (int i = 0; i < RAND_COUNT; i++) begin
            vec            = '0;
            vec.regwrite   = 1'b1;
            vec.resultsrc  = RES_MEM;
            vec.loadtype   = LD_W;
            vec.alu_result = {21'b0, rand_idx[i], 2'b00};
            vec.rd_addr    = reg_addr_t'((i % 31) + 1);
            apply_vector(vec, ref_mem[rand_idx[i]]);
        end

        // Idle cycles drain the last write
        apply_vector('0, '0);
        apply_vector('0, '0);

        if (u_dut.u_properties.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            abort_run("A bound assertion on rv_mem_top failed");
        end
    end

endmodule

`default_nettype wire

// File: files.f
source/rv_mem_pkg.sv
source/data_memory.sv
source/memory_stage.sv
source/writeback_stage.sv
source/rv_mem_top.sv
test/rv_mem_properties.sv
test/tb_rv_mem.sv

// File: test/rv_mem_tests.txt
# Columns: regwrite memwrite resultsrc storetype loadtype alu_result write_data rd_addr pc4 expected_rf_data
# All hex. resultsrc 0=ALU 1=MEM 2=PC4, storetype 0=B 1=H 2=W, loadtype 0=B 1=H 2=W 4=BU 5=HU
# expected_rf_data is only checked when regwrite is set and rd_addr is nonzero
# After reset, regwrite low
0 0 0 2 2 00000010 00000000 05 004 00000000
# ALU and PC+4 results back to back
1 0 0 2 2 12345678 00000000 01 008 12345678
1 0 0 2 2 DEADBEEF 00000000 02 00C DEADBEEF
1 0 2 2 2 00000100 00000000 03 7FC 000007FC
1 0 2 2 2 00000000 00000000 04 104 00000104
1 0 0 2 2 80000001 00000000 1F 110 80000001
0 0 2 2 2 00000000 00000000 06 200 00000000
# Word store, then load of the same word
0 1 0 2 2 00000040 CAFEF00D 00 000 00000000
1 0 1 2 2 00000040 00000000 05 000 CAFEF00D
# Store and load in the same cycle, load sees the old word
1 1 1 2 2 00000040 11223344 06 000 CAFEF00D
1 0 1 2 2 00000040 00000000 07 000 11223344
# Address bits above 10 ignored
1 0 1 2 2 FFFFF840 00000000 08 000 11223344
# Byte stores at each offset of a cleared word
0 1 0 2 2 00000080 00000000 00 000 00000000
0 1 0 0 2 00000080 FFFFFF11 00 000 00000000
1 0 1 2 2 00000080 00000000 09 000 00000011
0 1 0 0 2 00000081 FFFFFF22 00 000 00000000
1 0 1 2 2 00000080 00000000 0A 000 00002211
0 1 0 0 2 00000082 12345633 00 000 00000000
1 0 1 2 2 00000080 00000000 0B 000 00332211
0 1 0 0 2 00000083 000000F4 00 000 00000000
1 0 1 2 2 00000080 00000000 0C 000 F4332211
# Halfword stores, address bit 0 ignored
0 1 0 2 2 000000C0 FFFFFFFF 00 000 00000000
0 1 0 1 2 000000C0 AAAA1234 00 000 00000000
1 0 1 2 2 000000C0 00000000 0D 000 FFFF1234
0 1 0 1 2 000000C2 00005678 00 000 00000000
1 0 1 2 2 000000C0 00000000 0E 000 56781234
0 1 0 1 2 000000C1 0000ABCD 00 000 00000000
1 0 1 2 2 000000C0 00000000 0F 000 5678ABCD
0 1 0 1 2 000000C3 FFFF9876 00 000 00000000
1 0 1 2 2 000000C0 00000000 10 000 9876ABCD
# Word store ignores the byte offset
0 1 0 2 2 000000C5 0BADCAFE 00 000 00000000
1 0 1 2 2 000000C4 00000000 11 000 0BADCAFE
# Byte and halfword extension on a word with mixed signs
0 1 0 2 2 00000100 80FF7F01 00 000 00000000
1 0 1 2 0 00000100 00000000 12 000 00000001
1 0 1 2 0 00000101 00000000 13 000 0000007F
1 0 1 2 0 00000102 00000000 14 000 FFFFFFFF
1 0 1 2 0 00000103 00000000 15 000 FFFFFF80
1 0 1 2 4 00000100 00000000 16 000 00000001
1 0 1 2 4 00000101 00000000 17 000 0000007F
1 0 1 2 4 00000102 00000000 18 000 000000FF
1 0 1 2 4 00000103 00000000 19 000 00000080
1 0 1 2 1 00000100 00000000 1A 000 00007F01
1 0 1 2 1 00000102 00000000 1B 000 FFFF80FF
1 0 1 2 5 00000100 00000000 1C 000 00007F01
1 0 1 2 5 00000102 00000000 1D 000 000080FF
# Negative low half, odd offsets
0 1 0 2 2 00000104 0123FEDC 00 000 00000000
1 0 1 2 1 00000104 00000000 1E 000 FFFFFEDC
1 0 1 2 5 00000104 00000000 01 000 0000FEDC
1 0 1 2 1 00000106 00000000 02 000 00000123
1 0 1 2 1 00000105 00000000 03 000 FFFFFEDC
1 0 1 2 5 00000107 00000000 04 000 00000123
# Register x0 is never written
1 0 0 2 2 00000055 00000000 00 000 00000000
1 0 1 2 2 00000100 00000000 00 000 00000000
1 0 2 2 2 00000000 00000000 00 3FC 00000000
# Normal write right after x0
1 0 0 2 2 0000AAAA 00000000 05 000 0000AAAA
